//--- decode_stage.sv
// ****************************************
// Decode holding register
// Operand read and issue into execute
// Input handshake with stall back-pressure
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  output logic               instr_ready,
  input  pipe_pkg::instr_t   instr,
  output pipe_pkg::reg_idx_t rd_idx_a,
  output pipe_pkg::reg_idx_t rd_idx_b,
  input  pipe_pkg::data_t    rd_data_a,
  input  pipe_pkg::data_t    rd_data_b,
  input  logic               stall,
  output pipe_pkg::instr_t   dec_instr,
  output logic               dec_valid,
  output logic               issue_valid,
  output pipe_pkg::ex_rec_t  issue_rec
);
  import pipe_pkg::*;

  logic       full_q;
  logic       run_q;
  instr_t     instr_q;
  logic [1:0] reads;
  logic       issue;
  logic       accept;

  assign issue  = full_q && !stall;
  // Ready stays low until the first edge after reset release
  assign instr_ready = run_q && (!full_q || issue);
  assign accept = instr_valid && instr_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      run_q  <= 1'b0;
      full_q <= 1'b0;
    end
    else
    begin
      run_q <= 1'b1;
      if (accept)
        full_q <= 1'b1;
      else if (issue)
        full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      instr_q <= instr;
  end

  // Unused source ports read register 0
  assign reads    = src_reads(instr_q.op);
  assign rd_idx_a = reads[0] ? instr_q.src1 : '0;
  assign rd_idx_b = reads[1] ? instr_q.src2 : '0;

  assign dec_valid = full_q;
  assign dec_instr = instr_q;

  // A stall turns the issue slot into a bubble
  assign issue_valid = issue;

  always_comb
  begin
    issue_rec.op  = instr_q.op;
    issue_rec.dst = dst_info(instr_q);
    issue_rec.opa = rd_data_a;
    issue_rec.opb = rd_data_b;
    issue_rec.imm = instr_q.imm;
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
// ****************************************
// Execute pipeline register and ALU
// Result or memory address for the next stage
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue_valid,
  input  pipe_pkg::ex_rec_t   issue_rec,
  output pipe_pkg::dst_info_t ex_dst,
  output logic                mem_valid,
  output pipe_pkg::mem_rec_t  mem_rec
);
  import pipe_pkg::*;

  logic    valid_q;
  ex_rec_t rec_q;
  data_t   alu_res;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      valid_q <= 1'b0;
    else
      valid_q <= issue_valid;
  end

  // Bubbles leave the payload untouched
  always_ff @(posedge clk)
  begin
    if (issue_valid)
      rec_q <= issue_rec;
  end

  // All arithmetic wraps at the data width
  always_comb
  begin
    case (rec_q.op)
      ADD:         alu_res = rec_q.opa + rec_q.opb;
      SUB:         alu_res = rec_q.opa - rec_q.opb;
      AND:         alu_res = rec_q.opa & rec_q.opb;
      XOR:         alu_res = rec_q.opa ^ rec_q.opb;
      LI:          alu_res = rec_q.imm;
      // Base register plus offset
      LOAD, STORE: alu_res = rec_q.opa + rec_q.imm;
      default:     alu_res = '0;
    endcase
  end

  // Pending write seen by the hazard unit
  assign ex_dst = valid_q ? rec_q.dst : '0;

  assign mem_valid = valid_q;

  always_comb
  begin
    mem_rec.op      = rec_q.op;
    mem_rec.dst     = rec_q.dst;
    mem_rec.res     = alu_res;
    // Store data comes from the second operand
    mem_rec.st_data = rec_q.opb;
  end

endmodule

`default_nettype wire

//--- flist.f
pipe_pkg.sv
reg_file.sv
hazard_detect.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
pipe_core.sv
pipe_core_asserts.sv
tb_pipe_core.sv

//--- hazard_detect.sv
// ****************************************
// Read-after-write hazard check
// Decoded sources against execute and memory stage
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module hazard_detect (
  input  logic                dec_valid,
  input  pipe_pkg::instr_t    dec_instr,
  input  pipe_pkg::dst_info_t ex_dst,
  input  pipe_pkg::dst_info_t mem_dst,
  output logic                stall
);
  import pipe_pkg::*;

  logic [1:0] reads;
  logic       hit_a;
  logic       hit_b;

  // True when a source matches a pending write in either stage
  function automatic logic pending(reg_idx_t src, dst_info_t ex, dst_info_t mem);
    logic ex_hit;
    logic mem_hit;
    ex_hit  = ex.valid && (ex.idx == src);
    mem_hit = mem.valid && (mem.idx == src);
    return ex_hit || mem_hit;
  endfunction

  always_comb
  begin
    reads = src_reads(dec_instr.op);

    // Register 0 is a constant, never a hazard
    // Destination markers already exclude it, check the source as well
    hit_a = reads[0] && (dec_instr.src1 != '0) &&
            pending(dec_instr.src1, ex_dst, mem_dst);
    hit_b = reads[1] && (dec_instr.src2 != '0) &&
            pending(dec_instr.src2, ex_dst, mem_dst);

    // Writeback is covered by the register file bypass
    stall = dec_valid && (hit_a || hit_b);
  end

endmodule

`default_nettype wire

//--- mem_stage.sv
// ****************************************
// Two-cycle memory stage
// Address register, data memory, writeback register
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
  parameter int MEM_DEPTH = 16
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_valid,
  input  pipe_pkg::mem_rec_t  mem_rec,
  output pipe_pkg::dst_info_t mem_dst,
  output pipe_pkg::wb_t       wb
);
  import pipe_pkg::*;

  localparam int addr_w = $clog2(MEM_DEPTH);

  logic              valid_q;
  mem_rec_t          rec_q;
  data_t             mem [MEM_DEPTH];
  logic [addr_w-1:0] addr;
  logic              wb_valid_q;
  reg_idx_t          wb_dst_q;
  data_t             wb_data_q;

  // Address register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      valid_q <= 1'b0;
    else
      valid_q <= mem_valid;
  end

  always_ff @(posedge clk)
  begin
    if (mem_valid)
      rec_q <= mem_rec;
  end

  // Low bits only, so addresses wrap at the memory depth
  assign addr = rec_q.res[addr_w-1:0];

  // Data memory, store commits at the end of the address cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < MEM_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (valid_q && (rec_q.op == STORE))
    begin
      mem[addr] <= rec_q.st_data;
    end
  end

  // Writeback register doubles as the synchronous read register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      wb_valid_q <= 1'b0;
    else
      wb_valid_q <= valid_q && rec_q.dst.valid;
  end

  always_ff @(posedge clk)
  begin
    if (valid_q)
    begin
      wb_dst_q  <= rec_q.dst.idx;
      wb_data_q <= (rec_q.op == LOAD) ? mem[addr] : rec_q.res;
    end
  end

  assign mem_dst = valid_q ? rec_q.dst : '0;

  always_comb
  begin
    wb.valid = wb_valid_q;
    wb.dst   = wb_dst_q;
    wb.data  = wb_data_q;
  end

endmodule

`default_nettype wire

//--- pipe_core.sv
// ****************************************
// Pipeline top level
// Decode, register file, hazard unit, execute, memory
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module pipe_core #(
  parameter int MEM_DEPTH = 16
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  output logic               instr_ready,
  input  pipe_pkg::instr_t   instr,
  output logic               wb_valid,
  output pipe_pkg::reg_idx_t wb_dst,
  output pipe_pkg::data_t    wb_data
);
  import pipe_pkg::*;

  reg_idx_t  rd_idx_a;
  reg_idx_t  rd_idx_b;
  data_t     rd_data_a;
  data_t     rd_data_b;
  logic      stall;
  instr_t    dec_instr;
  logic      dec_valid;
  logic      issue_valid;
  ex_rec_t   issue_rec;
  dst_info_t ex_dst;
  logic      mem_valid;
  mem_rec_t  mem_rec;
  dst_info_t mem_dst;
  wb_t       wb;

  decode_stage i_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .rd_idx_a    (rd_idx_a),
    .rd_idx_b    (rd_idx_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .stall       (stall),
    .dec_instr   (dec_instr),
    .dec_valid   (dec_valid),
    .issue_valid (issue_valid),
    .issue_rec   (issue_rec)
  );

  // Writeback feeds the register file directly
  reg_file i_reg_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (wb)
  );

  hazard_detect i_hazard_detect (
    .dec_valid (dec_valid),
    .dec_instr (dec_instr),
    .ex_dst    (ex_dst),
    .mem_dst   (mem_dst),
    .stall     (stall)
  );

  execute_stage i_execute_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_rec   (issue_rec),
    .ex_dst      (ex_dst),
    .mem_valid   (mem_valid),
    .mem_rec     (mem_rec)
  );

  mem_stage #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_mem_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_valid (mem_valid),
    .mem_rec   (mem_rec),
    .mem_dst   (mem_dst),
    .wb        (wb)
  );

  // Split the writeback record onto the ports
  assign wb_valid = wb.valid;
  assign wb_dst   = wb.dst;
  assign wb_data  = wb.data;

endmodule

`default_nettype wire

//--- pipe_core_asserts.sv
// ****************************************
// Concurrent checks on the pipeline top level
// Input handshake, writeback index, reset release
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module pipe_core_asserts (
  input logic               clk,
  input logic               arst_n,
  input logic               instr_valid,
  input logic               instr_ready,
  input pipe_pkg::instr_t   instr,
  input logic               wb_valid,
  input pipe_pkg::reg_idx_t wb_dst
);
  import pipe_pkg::*;

  // Number of failed assertions so far
  int fail_cnt;

  // Source keeps the word while it waits for ready
  instr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (instr_valid && !instr_ready) |=> $stable(instr))
    else
    begin
      fail_cnt++;
      $error("instr changed while instr_valid was high and instr_ready low");
    end

  // Register 0 is never a writeback target
  wb_dst_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid |-> (wb_dst != '0))
    else
    begin
      fail_cnt++;
      $error("writeback to register 0");
    end

  // Nothing comes out of the pipeline right after reset
  wb_idle_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !wb_valid)
    else
    begin
      fail_cnt++;
      $error("wb_valid high in the first cycle after reset release");
    end

endmodule

bind pipe_core pipe_core_asserts i_pipe_core_asserts (.*);

`default_nettype wire

//--- pipe_pkg.sv
// ****************************************
// Shared widths, register index and data types
// Opcode enumeration, instruction and stage records
// Destination and source-use helper functions
// ****************************************
`default_nettype none

package pipe_pkg;

  parameter int data_w = 16;
  parameter int reg_n  = 8;

  typedef logic [$clog2(reg_n)-1:0] reg_idx_t;
  typedef logic [data_w-1:0]        data_t;

  // Opcode 3'd7 is unused and decodes as a no-write ALU op
  typedef enum logic [2:0] {
    ADD   = 3'd0,
    SUB   = 3'd1,
    AND   = 3'd2,
    XOR   = 3'd3,
    LI    = 3'd4,
    LOAD  = 3'd5,
    STORE = 3'd6
  } op_e;

  // 28-bit instruction word
  typedef struct packed {
    op_e      op;
    reg_idx_t dst;
    reg_idx_t src1;
    reg_idx_t src2;
    data_t    imm;
  } instr_t;

  // In-flight register write marker
  typedef struct packed {
    logic     valid;
    reg_idx_t idx;
  } dst_info_t;

  // Instruction sitting in execute
  typedef struct packed {
    op_e       op;
    dst_info_t dst;
    data_t     opa;
    data_t     opb;
    data_t     imm;
  } ex_rec_t;

  // Record in the memory address register
  typedef struct packed {
    op_e       op;
    dst_info_t dst;
    data_t     res;
    data_t     st_data;
  } mem_rec_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dst;
    data_t    data;
  } wb_t;

  // Writing opcodes only, and never register 0
  function automatic dst_info_t dst_info(instr_t i);
    dst_info_t d;
    case (i.op)
      ADD, SUB, AND, XOR, LI, LOAD: d.valid = (i.dst != '0);
      default:                      d.valid = 1'b0;
    endcase
    d.idx = i.dst;
    return d;
  endfunction

  // Bit 0 set when src1 is read, bit 1 when src2 is read
  function automatic logic [1:0] src_reads(op_e op);
    case (op)
      LI:      return 2'b00;
      LOAD:    return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- reg_file.sv
// ****************************************
// Eight-entry register file
// Two read ports, one write port, write-through
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  pipe_pkg::reg_idx_t rd_idx_a,
  input  pipe_pkg::reg_idx_t rd_idx_b,
  output pipe_pkg::data_t    rd_data_a,
  output pipe_pkg::data_t    rd_data_b,
  input  pipe_pkg::wb_t      wb
);
  import pipe_pkg::*;

  data_t regs [reg_n];
  logic  wr_en;

  // Entry 0 is never written, so it stays at its reset value of zero
  assign wr_en = wb.valid && (wb.dst != '0);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < reg_n; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wb.dst] <= wb.data;
    end
  end

  // Same-cycle bypass of the write data
  // Decode sees a writeback one cycle early, no comparison needed in wb
  assign rd_data_a = (wr_en && (wb.dst == rd_idx_a)) ? wb.data : regs[rd_idx_a];
  assign rd_data_b = (wr_en && (wb.dst == rd_idx_b)) ? wb.data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- tb_pipe_core.sv
// ****************************************
// Testbench for the pipeline top level
// Random programs, sequential reference model
// Writeback checker, clock, reset and timeout
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_core;
  import pipe_pkg::*;

  // Expected writeback with a flag for a dependent pair three cycles apart
  typedef struct packed {
    reg_idx_t dst;
    data_t    data;
    logic     gap_chk;
  } exp_t;

  localparam int total_instr    = 460;
  // 3 stall cycles, up to 4 idle cycles, plus 1 per instruction
  localparam int timeout_cycles = total_instr * 8 + 50;

  logic     clk;
  logic     arst_n;
  logic     instr_valid;
  logic     instr_ready;
  instr_t   instr;
  logic     wb_valid;
  reg_idx_t wb_dst;
  data_t    wb_data;

  // Reference model state
  data_t m_regs [reg_n];
  data_t m_mem [16];
  exp_t  exp_q [$];
  exp_t  head;
  int    cycle_cnt;
  int    last_wb;
  int    wb_cnt;
  int    exp_cnt;
  int    errors;
  int    seed_val;

  pipe_core #(
    .MEM_DEPTH (16)
  ) i_pipe_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_dst      (wb_dst),
    .wb_data     (wb_data)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
    cycle_cnt = cycle_cnt + 1;

  function automatic reg_idx_t rand_reg(input int lo);
    return reg_idx_t'(lo + ($urandom % (reg_n - lo)));
  endfunction

  // Any register except the two given ones
  function automatic reg_idx_t pick_away(input reg_idx_t x, input reg_idx_t y);
    reg_idx_t r;
    r = rand_reg(0);
    while ((r == x) || (r == y))
      r = rand_reg(0);
    return r;
  endfunction

  // First count opcodes of the enumeration
  function automatic op_e rand_op(input int count);
    return op_e'(3'($urandom % count));
  endfunction

  // Execute one instruction in program order and queue its writeback
  task automatic run_model(input instr_t i, input logic gap_chk);
    data_t a;
    data_t b;
    data_t res;
    data_t addr;
    logic  writes;
    exp_t  e;
    a      = m_regs[i.src1];
    b      = m_regs[i.src2];
    addr   = a + i.imm;
    writes = 1'b1;
    case (i.op)
      ADD:  res = a + b;
      SUB:  res = a - b;
      AND:  res = a & b;
      XOR:  res = a ^ b;
      LI:   res = i.imm;
      LOAD: res = m_mem[addr % 16];
      default:
      begin
        // STORE writes memory from src2
        m_mem[addr % 16] = b;
        res    = '0;
        writes = 1'b0;
      end
    endcase
    if (writes && (i.dst != '0))
    begin
      m_regs[i.dst] = res;
      e.dst     = i.dst;
      e.data    = res;
      e.gap_chk = gap_chk;
      exp_q.push_back(e);
      exp_cnt++;
    end
  endtask

  // Hold the word until a rising edge sees valid and ready together
  task automatic send_instr(input instr_t i);
    logic acc;
    instr_valid = 1'b1;
    instr       = i;
    acc         = 1'b0;
    while (!acc)
    begin
      @(negedge clk);
      acc = instr_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_test(input int num, input int mode, input string name);
    instr_t   i;
    reg_idx_t prev_dst;
    reg_idx_t recent_a;
    reg_idx_t recent_b;
    logic     gap;
    logic     after_load;
    int       gap_cycles;
    int       err_start;
    int       wb_start;
    int       exp_start;
    err_start  = errors;
    wb_start   = wb_cnt;
    exp_start  = exp_cnt;
    prev_dst   = '0;
    recent_a   = '0;
    recent_b   = '0;
    after_load = 1'b0;
    for (int n = 0; n < num; n++)
    begin
      i.op   = rand_op(7);
      i.dst  = rand_reg(0);
      i.src1 = rand_reg(0);
      i.src2 = rand_reg(0);
      i.imm  = data_t'($urandom);
      gap    = 1'b0;
      case (mode)
        1:
        begin
          // No source touches the last two destinations
          i.op     = rand_op(5);
          i.dst    = rand_reg(1);
          i.src1   = pick_away(recent_a, recent_b);
          i.src2   = pick_away(recent_a, recent_b);
          recent_b = recent_a;
          recent_a = i.dst;
        end
        2:
        begin
          i.dst = rand_reg(1);
          if ((n % 8) == 0)
            i.op = LI;
          else
          begin
            i.op = rand_op(4);
            gap  = 1'b1;
            if ($urandom % 2)
              i.src1 = prev_dst;
            else
              i.src2 = prev_dst;
          end
        end
        3:
        begin
          if (after_load)
          begin
            // Load-use pair
            i.op       = rand_op(4);
            i.dst      = rand_reg(1);
            i.src1     = prev_dst;
            gap        = 1'b1;
            after_load = 1'b0;
          end
          else
          begin
            case ($urandom % 3)
              0: i.op = LI;
              1: i.op = STORE;
              default: i.op = LOAD;
            endcase
            i.dst      = rand_reg(1);
            after_load = (i.op == LOAD);
          end
        end
        4:
        begin
          // At least one field forced to register 0
          case ($urandom % 3)
            0: i.dst = '0;
            1: i.src1 = '0;
            default: i.src2 = '0;
          endcase
        end
        default: ;
      endcase
      if (i.op != STORE)
        prev_dst = i.dst;
      run_model(i, gap);
      send_instr(i);
      if ((mode == 5) && (n < num - 1))
      begin
        gap_cycles = $urandom % 4;
        instr_valid = (gap_cycles == 0);
        repeat (gap_cycles)
        begin
          @(posedge clk);
          #1;
        end
      end
    end
    instr_valid = 1'b0;
    // Drain the queue and wait a few idle cycles for a stray writeback
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (6) @(posedge clk);
    #1;
    assert ((wb_cnt - wb_start) == (exp_cnt - exp_start))
    else
    begin
      $display("Writeback count %0d does not match the model count %0d",
               wb_cnt - wb_start, exp_cnt - exp_start);
      errors++;
    end
    $display("Test %0d %s: %0d instructions, %0d writebacks, %0d errors",
             mode, name, num, wb_cnt - wb_start, errors - err_start);
  endtask

  // Writeback checker on the falling clock edge
  always @(negedge clk)
  begin
    if (arst_n && wb_valid)
    begin
      wb_cnt++;
      assert (exp_q.size() != 0)
      else
      begin
        $display("Writeback to register %0d with no instruction expecting one", wb_dst);
        errors++;
      end
      if (exp_q.size() != 0)
      begin
        head = exp_q.pop_front();
        assert (wb_dst == head.dst)
        else
        begin
          $display("** Error: wb_dst expected %h, got %h", head.dst, wb_dst);
          errors++;
        end
        assert (wb_data == head.data)
        else
        begin
          $display("** Error: wb_data expected %h, got %h", head.data, wb_data);
          errors++;
        end
        if (head.gap_chk)
        begin
          assert ((cycle_cnt - last_wb) == 3)
          else
          begin
            $display("Dependent writeback came %0d cycles after its producer, not 3",
                     cycle_cnt - last_wb);
            errors++;
          end
        end
      end
      last_wb = cycle_cnt;
    end
  end

  initial
  begin
    wait (cycle_cnt >= timeout_cycles);
    $display("Run timed out after %0d cycles with %0d writebacks outstanding",
             cycle_cnt, exp_q.size());
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    seed_val    = $urandom(32'h00f1caa2);
    for (int r = 0; r < reg_n; r++)
      m_regs[r] = '0;
    for (int a = 0; a < 16; a++)
      m_mem[a] = '0;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    run_test(100, 1, "independent ALU stream");
    run_test(60, 2, "dependent chains");
    run_test(60, 3, "load-use and store-then-load");
    run_test(40, 4, "register 0 rules");
    run_test(200, 5, "random mix with gaps");
    // Failures of the bound concurrent assertions
    errors = errors + i_pipe_core.i_pipe_core_asserts.fail_cnt;
    $display("Totals: %0d instructions, %0d writebacks, %0d expected, %0d errors",
             total_instr, wb_cnt, exp_cnt, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
